//--- rv_execute.f
rtl/rv_exec_pkg.sv
rtl/rv_alu.sv
rtl/rv_branch_cmp.sv
rtl/rv_exec_stage.sv
rtl/rv_exec_top.sv
bench/rv_exec_asserts.sv
bench/rv_exec_tb.sv

//--- bench/rv_exec_tb.sv
// Testbench for the execute stage top level
// Clock, reset, random and directed instruction stimulus
// One-entry reference model with immediate assertion checks

`timescale 1ns/1ps

module rv_exec_tb;
    import rv_exec_pkg::*;

    // Run length
    localparam int NUM_RANDOM = 2000;
    localparam int MAX_CYCLES = 3000;

    logic         clk;
    logic         rst_n;
    logic         stall;
    logic         flush;
    logic         in_valid;
    word_t        pc;
    word_t        rs1_val;
    word_t        rs2_val;
    word_t        immediate;
    word_t        csr_old_val;
    zimm_t        csr_zimm;
    alu_op_e      alu_op;
    alu_op1_src_e alu_op1_src;
    alu_op2_src_e alu_op2_src;
    cmp_op_e      cmp_op;
    csr_op_src_e  csr_op_src;
    csr_alu_op_e  csr_alu_op;
    reg_idx_t     rd_idx;
    logic         rd_we;
    logic         out_valid;
    word_t        out_pc;
    word_t        alu_result;
    word_t        csr_new_val;
    word_t        out_rs2_val;
    logic         branch_taken;
    reg_idx_t     out_rd_idx;
    logic         out_rd_we;

    // Reference model, one held instruction
    logic         exp_valid;
    word_t        exp_alu;
    logic         exp_taken;
    word_t        exp_csr;
    word_t        exp_pc;
    word_t        exp_rs2;
    reg_idx_t     exp_rd_idx;
    logic         exp_rd_we;

    integer       seed;
    int           errors;
    int           cycles;
    int           total;

    rv_exec_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Uniform pick in 0 .. n-1
    function automatic int unsigned pick(input int unsigned n);
        pick = $unsigned($random(seed)) % n;
    endfunction

    // RV32I semantics, signed compare by flipping sign bits
    function automatic word_t ref_alu(input word_t a, input word_t b, input alu_op_e op);
        logic [4:0] sh;
        word_t      fill;
        sh   = b[4:0];
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
        case (op)
            ALU_ADD:  ref_alu = a + b;
            ALU_SUB:  ref_alu = a + ~b + 32'd1;
            ALU_SLL:  ref_alu = a << sh;
            ALU_SLT:  ref_alu = {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            ALU_SLTU: ref_alu = {31'b0, a < b};
            ALU_XOR:  ref_alu = a ^ b;
            ALU_SRL:  ref_alu = a >> sh;
            ALU_SRA:  ref_alu = (a >> sh) | fill;
            ALU_OR:   ref_alu = a | b;
            ALU_AND:  ref_alu = a & b;
            default:  ref_alu = 32'h0;
        endcase
    endfunction

    function automatic logic ref_taken(input word_t a, input word_t b, input cmp_op_e op);
        logic lt_s;
        logic lt_u;
        lt_u = a < b;
        lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
        case (op)
            CMP_EQ:  ref_taken = (a == b);
            CMP_NE:  ref_taken = (a != b);
            CMP_LT:  ref_taken = lt_s;
            CMP_GE:  ref_taken = !lt_s;
            CMP_LTU: ref_taken = lt_u;
            CMP_GEU: ref_taken = !lt_u;
            default: ref_taken = 1'b0;
        endcase
    endfunction

    // Passthrough, set or clear with rs1 or zimm operand
    function automatic word_t ref_csr(input word_t old, input word_t src_rs1, input zimm_t zimm,
                                      input csr_op_src_e src, input csr_alu_op_e op);
        word_t opnd;
        opnd = (src == CSR_OP_SRC_ZIMM) ? {27'b0, zimm} : src_rs1;
        case (op)
            CSR_ALU_OP_PASSTHRU: ref_csr = opnd;
            CSR_ALU_OP_BITSET:   ref_csr = old | opnd;
            CSR_ALU_OP_BITCLEAR: ref_csr = old & ~opnd;
            default:             ref_csr = old;
        endcase
    endfunction

    function automatic word_t select_op1();
        case (alu_op1_src)
            ALU_OP1_SRC_RS1: select_op1 = rs1_val;
            ALU_OP1_SRC_PC:  select_op1 = pc;
            ALU_OP1_SRC_CSR: select_op1 = csr_old_val;
            default:         select_op1 = 32'h0;
        endcase
    endfunction

    function automatic word_t select_op2();
        case (alu_op2_src)
            ALU_OP2_SRC_RS1: select_op2 = rs1_val;
            ALU_OP2_SRC_RS2: select_op2 = rs2_val;
            ALU_OP2_SRC_IMM: select_op2 = immediate;
            default:         select_op2 = 32'd4;
        endcase
    endfunction

    // Model capture follows the stage register rule
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_valid <= 1'b0;
        end else if (!stall) begin
            exp_valid  <= in_valid;
            exp_alu    <= ref_alu(select_op1(), select_op2(), alu_op);
            exp_taken  <= ref_taken(rs1_val, rs2_val, cmp_op);
            exp_csr    <= ref_csr(csr_old_val, rs1_val, csr_zimm, csr_op_src, csr_alu_op);
            exp_pc     <= pc;
            exp_rs2    <= rs2_val;
            exp_rd_idx <= rd_idx;
            exp_rd_we  <= rd_we;
        end
    end

    // Cycle limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors: %0d checks, %0d assertions", errors, DUT.u_asserts.assert_fails);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic report_fail(input string msg);
        $display("Fail %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic randomize_fields();
        pc          = $random(seed);
        rs1_val     = $random(seed);
        rs2_val     = $random(seed);
        immediate   = $random(seed);
        csr_old_val = $random(seed);
        csr_zimm    = zimm_t'(pick(32));
        alu_op      = alu_op_e'(pick(10));
        alu_op1_src = alu_op1_src_e'(pick(4));
        alu_op2_src = alu_op2_src_e'(pick(4));
        cmp_op      = cmp_op_e'(pick(6));
        csr_op_src  = csr_op_src_e'(pick(2));
        csr_alu_op  = csr_alu_op_e'(pick(3));
        rd_idx      = reg_idx_t'(pick(32));
        rd_we       = pick(2);
    endtask

    // Outputs settle 2 ns after the falling edge
    task automatic check_outputs();
        assert (out_valid === (exp_valid && !stall && !flush))
            else report_fail($sformatf("out_valid %b, model valid %b", out_valid, exp_valid));
        if (exp_valid) begin
            assert (alu_result === exp_alu)
                else report_fail($sformatf("alu_result %h expected %h", alu_result, exp_alu));
            assert (branch_taken === exp_taken)
                else report_fail($sformatf("branch_taken %b expected %b", branch_taken, exp_taken));
            assert (csr_new_val === exp_csr)
                else report_fail($sformatf("csr_new_val %h expected %h", csr_new_val, exp_csr));
            assert (out_pc === exp_pc && out_rs2_val === exp_rs2)
                else report_fail($sformatf("out_pc %h out_rs2_val %h", out_pc, out_rs2_val));
            assert (out_rd_idx === exp_rd_idx && out_rd_we === exp_rd_we)
                else report_fail($sformatf("out_rd_idx %0d out_rd_we %b", out_rd_idx, out_rd_we));
        end
    endtask

    task automatic drive_cycle(input logic v, input logic s, input logic f);
        @(negedge clk);
        randomize_fields();
        in_valid = v;
        stall    = s;
        flush    = f;
        #2;
        check_outputs();
    endtask

    task automatic apply_branch(input word_t a, input word_t b, input cmp_op_e op);
        @(negedge clk);
        randomize_fields();
        rs1_val  = a;
        rs2_val  = b;
        cmp_op   = op;
        in_valid = 1'b1;
        stall    = 1'b0;
        flush    = 1'b0;
        #2;
        check_outputs();
    endtask

    initial begin
        seed      = 41;
        errors    = 0;
        cycles    = 0;
        exp_valid = 1'b0;
        rst_n     = 1'b0;
        stall     = 1'b0;
        flush     = 1'b0;
        in_valid  = 1'b0;
        randomize_fields();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        // Random mix, occasional stall and flush
        for (int i = 0; i < NUM_RANDOM; i++) begin
            drive_cycle(pick(8) != 0, pick(16) == 0, pick(16) == 0);
        end

        // Equal, negative and unsigned wrap operands
        for (int k = 0; k < 6; k++) begin
            apply_branch(32'h1234_5678, 32'h1234_5678, cmp_op_e'(k));
            apply_branch(32'hffff_ffff, 32'h0000_0001, cmp_op_e'(k));
            apply_branch(32'h0000_0001, 32'hffff_ffff, cmp_op_e'(k));
            apply_branch(32'h8000_0000, 32'h7fff_ffff, cmp_op_e'(k));
            apply_branch(32'h0000_0000, 32'hffff_ffff, cmp_op_e'(k));
        end

        // Held instruction across a stall with changing inputs
        drive_cycle(1'b1, 1'b0, 1'b0);
        repeat (5) drive_cycle(1'b1, 1'b1, 1'b0);
        drive_cycle(1'b0, 1'b0, 1'b0);
        assert (out_valid === 1'b1)
            else report_fail("held instruction not presented after stall dropped");
        repeat (2) drive_cycle(1'b0, 1'b0, 1'b0);

        total = errors + DUT.u_asserts.assert_fails;
        $display("Errors: %0d checks, %0d assertions", errors, DUT.u_asserts.assert_fails);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- bench/rv_exec_asserts.sv
// Concurrent timing checks for the execute stage top level
// Valid after reset, gating by stall and flush, one-cycle latency

`timescale 1ns/1ps

module rv_exec_asserts (
    input logic clk,
    input logic rst_n,
    input logic stall,
    input logic flush,
    input logic in_valid,
    input logic out_valid
);

    // Failure count
    int assert_fails = 0;

    // Set once a valid instruction is accepted after reset
    logic captured;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            captured <= 1'b0;
        end else if (in_valid && !stall) begin
            captured <= 1'b1;
        end
    end

    // Nothing presented before the first capture
    a_idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !captured |-> !out_valid)
        else begin
            $error("out_valid high before any instruction was captured");
            assert_fails++;
        end

    a_gated: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (!stall && !flush))
        else begin
            $error("out_valid high during stall or flush");
            assert_fails++;
        end

    // Accepted instruction shows one cycle later
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && !stall) |=> (out_valid || stall || flush))
        else begin
            $error("accepted instruction missing out_valid on the next cycle");
            assert_fails++;
        end

endmodule

bind rv_exec_top rv_exec_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .flush     (flush),
    .in_valid  (in_valid),
    .out_valid (out_valid)
);

//--- rtl/rv_exec_top.sv
// Execute stage top level
// Outside port list around the execute stage core

`timescale 1ns/1ps

module rv_exec_top
    import rv_exec_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    // From the hazard unit
    input  logic         stall,
    input  logic         flush,

    // From decode
    input  logic         in_valid,
    input  word_t        pc,
    input  word_t        rs1_val,
    input  word_t        rs2_val,
    input  word_t        immediate,
    input  word_t        csr_old_val,
    input  zimm_t        csr_zimm,
    input  alu_op_e      alu_op,
    input  alu_op1_src_e alu_op1_src,
    input  alu_op2_src_e alu_op2_src,
    input  cmp_op_e      cmp_op,
    input  csr_op_src_e  csr_op_src,
    input  csr_alu_op_e  csr_alu_op,
    input  reg_idx_t     rd_idx,
    input  logic         rd_we,

    // To the memory stage
    output logic         out_valid,
    output word_t        out_pc,
    output word_t        alu_result,
    output word_t        csr_new_val,
    output word_t        out_rs2_val,
    output logic         branch_taken,
    output reg_idx_t     out_rd_idx,
    output logic         out_rd_we
);

    // Single stage instance, bind target sits here
    rv_exec_stage u_exec (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .flush        (flush),
        .in_valid     (in_valid),
        .pc           (pc),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .immediate    (immediate),
        .csr_old_val  (csr_old_val),
        .csr_zimm     (csr_zimm),
        .alu_op       (alu_op),
        .alu_op1_src  (alu_op1_src),
        .alu_op2_src  (alu_op2_src),
        .cmp_op       (cmp_op),
        .csr_op_src   (csr_op_src),
        .csr_alu_op   (csr_alu_op),
        .rd_idx       (rd_idx),
        .rd_we        (rd_we),
        .out_valid    (out_valid),
        .out_pc       (out_pc),
        .alu_result   (alu_result),
        .csr_new_val  (csr_new_val),
        .out_rs2_val  (out_rs2_val),
        .branch_taken (branch_taken),
        .out_rd_idx   (out_rd_idx),
        .out_rd_we    (out_rd_we)
    );

endmodule

//--- rtl/rv_exec_stage.sv
// Execute stage core
// Input registers, ALU operand muxes, CSR modify logic
// Branch compare hookup and output valid gating

`timescale 1ns/1ps

module rv_exec_stage
    import rv_exec_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    // Hazard unit levels
    input  logic         stall,
    input  logic         flush,

    // Decoded instruction
    input  logic         in_valid,
    input  word_t        pc,
    input  word_t        rs1_val,
    input  word_t        rs2_val,
    input  word_t        immediate,
    input  word_t        csr_old_val,
    input  zimm_t        csr_zimm,
    input  alu_op_e      alu_op,
    input  alu_op1_src_e alu_op1_src,
    input  alu_op2_src_e alu_op2_src,
    input  cmp_op_e      cmp_op,
    input  csr_op_src_e  csr_op_src,
    input  csr_alu_op_e  csr_alu_op,
    input  reg_idx_t     rd_idx,
    input  logic         rd_we,

    // Toward the memory stage
    output logic         out_valid,
    output word_t        out_pc,
    output word_t        alu_result,
    output word_t        csr_new_val,
    output word_t        out_rs2_val,
    output logic         branch_taken,
    output reg_idx_t     out_rd_idx,
    output logic         out_rd_we
);

    // Stage registers
    logic         valid_q;
    word_t        pc_q;
    word_t        rs1_val_q;
    word_t        rs2_val_q;
    word_t        immediate_q;
    word_t        csr_old_val_q;
    zimm_t        csr_zimm_q;
    alu_op_e      alu_op_q;
    alu_op1_src_e alu_op1_src_q;
    alu_op2_src_e alu_op2_src_q;
    cmp_op_e      cmp_op_q;
    csr_op_src_e  csr_op_src_q;
    csr_alu_op_e  csr_alu_op_q;
    reg_idx_t     rd_idx_q;
    logic         rd_we_q;

    // ALU operands after the source muxes
    word_t        alu_operand_a;
    word_t        alu_operand_b;

    // Comparator result
    logic         cmp_result;

    // CSR operand after the source mux
    word_t        csr_operand;

    // Valid is the only control bit with a reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= in_valid;
        end
    end

    // Payload captured on every unstalled edge
    always_ff @(posedge clk) begin
        if (!stall) begin
            pc_q          <= pc;
            rs1_val_q     <= rs1_val;
            rs2_val_q     <= rs2_val;
            immediate_q   <= immediate;
            csr_old_val_q <= csr_old_val;
            csr_zimm_q    <= csr_zimm;
            alu_op_q      <= alu_op;
            alu_op1_src_q <= alu_op1_src;
            alu_op2_src_q <= alu_op2_src;
            cmp_op_q      <= cmp_op;
            csr_op_src_q  <= csr_op_src;
            csr_alu_op_q  <= csr_alu_op;
            rd_idx_q      <= rd_idx;
            rd_we_q       <= rd_we;
        end
    end

    // First ALU operand
    always_comb begin
        case (alu_op1_src_q)
            ALU_OP1_SRC_RS1:  alu_operand_a = rs1_val_q;
            ALU_OP1_SRC_PC:   alu_operand_a = pc_q;
            ALU_OP1_SRC_CSR:  alu_operand_a = csr_old_val_q;
            ALU_OP1_SRC_ZERO: alu_operand_a = '0;
            default:          alu_operand_a = '0;
        endcase
    end

    // Second ALU operand, FOUR for link addresses
    always_comb begin
        case (alu_op2_src_q)
            ALU_OP2_SRC_RS1:  alu_operand_b = rs1_val_q;
            ALU_OP2_SRC_RS2:  alu_operand_b = rs2_val_q;
            ALU_OP2_SRC_IMM:  alu_operand_b = immediate_q;
            ALU_OP2_SRC_FOUR: alu_operand_b = word_t'(4);
            default:          alu_operand_b = '0;
        endcase
    end

    rv_alu u_alu (
        .operand_a (alu_operand_a),
        .operand_b (alu_operand_b),
        .operation (alu_op_q),
        .result    (alu_result)
    );

    // Branches always compare rs1 against rs2
    rv_branch_cmp u_branch_cmp (
        .rs1_val       (rs1_val_q),
        .rs2_val       (rs2_val_q),
        .cmp_operation (cmp_op_q),
        .cmp_result    (cmp_result)
    );

    // CSR operand, zimm zero extended
    always_comb begin
        case (csr_op_src_q)
            CSR_OP_SRC_RS1:  csr_operand = rs1_val_q;
            CSR_OP_SRC_ZIMM: csr_operand = {{(XLEN-$bits(zimm_t)){1'b0}}, csr_zimm_q};
            default:         csr_operand = '0;
        endcase
    end

    // CSR read-modify-write
    always_comb begin
        case (csr_alu_op_q)
            CSR_ALU_OP_PASSTHRU: csr_new_val = csr_operand;
            CSR_ALU_OP_BITSET:   csr_new_val = csr_old_val_q | csr_operand;
            CSR_ALU_OP_BITCLEAR: csr_new_val = csr_old_val_q & ~csr_operand;
            default:             csr_new_val = csr_old_val_q;
        endcase
    end

    // Held instruction hidden during stall, dropped on flush
    always_comb begin
        out_valid = valid_q && !flush && !stall;
    end

    // Passthrough toward memory
    always_comb begin
        out_pc       = pc_q;
        out_rs2_val  = rs2_val_q;
        out_rd_idx   = rd_idx_q;
        out_rd_we    = rd_we_q;
        branch_taken = cmp_result;
    end

endmodule

//--- rtl/rv_branch_cmp.sv
// Branch comparator for the execute stage
// Six RV32I branch conditions, signed and unsigned

`timescale 1ns/1ps

module rv_branch_cmp
    import rv_exec_pkg::*;
(
    // Register operands
    input  word_t   rs1_val,
    input  word_t   rs2_val,

    // Branch condition
    input  cmp_op_e cmp_operation,

    // Branch taken flag
    output logic    cmp_result
);

    // Shared comparisons
    logic equal;
    logic signed_lt;
    logic unsigned_lt;

    always_comb begin
        equal       = rs1_val == rs2_val;
        signed_lt   = $signed(rs1_val) < $signed(rs2_val);
        unsigned_lt = rs1_val < rs2_val;
    end

    // GE and GEU are the inverted less-than
    always_comb begin
        case (cmp_operation)
            CMP_EQ: begin
                cmp_result = equal;
            end
            CMP_NE: begin
                cmp_result = !equal;
            end
            CMP_LT: begin
                cmp_result = signed_lt;
            end
            CMP_GE: begin
                cmp_result = !signed_lt;
            end
            CMP_LTU: begin
                cmp_result = unsigned_lt;
            end
            CMP_GEU: begin
                cmp_result = !unsigned_lt;
            end
            default: begin
                // Never taken on unused codes
                cmp_result = 1'b0;
            end
        endcase
    end

endmodule

//--- rtl/rv_alu.sv
// Integer ALU for the execute stage
// Ten RV32I register and immediate operations, purely combinational

`timescale 1ns/1ps

module rv_alu
    import rv_exec_pkg::*;
(
    // Operands from the stage muxes
    input  word_t   operand_a,
    input  word_t   operand_b,

    // Selected operation
    input  alu_op_e operation,

    // Result toward the memory stage
    output word_t   result
);

    // Shift amount width for a 32-bit word
    localparam int SHAMT_W = $clog2(XLEN);

    // Only the low bits of operand_b shift
    logic [SHAMT_W-1:0] shamt;

    // Comparison flags for SLT and SLTU
    logic signed_lt;
    logic unsigned_lt;

    // Adder and subtractor outputs
    word_t sum;
    word_t diff;

    always_comb begin
        shamt = operand_b[SHAMT_W-1:0];
    end

    always_comb begin
        sum  = operand_a + operand_b;
        diff = operand_a - operand_b;
    end

    always_comb begin
        signed_lt   = $signed(operand_a) < $signed(operand_b);
        unsigned_lt = operand_a < operand_b;
    end

    // Operation select
    always_comb begin
        case (operation)
            ALU_ADD: begin
                result = sum;
            end
            ALU_SUB: begin
                result = diff;
            end
            ALU_SLL: begin
                result = operand_a << shamt;
            end
            ALU_SLT: begin
                // Zero or one
                result = {{(XLEN-1){1'b0}}, signed_lt};
            end
            ALU_SLTU: begin
                result = {{(XLEN-1){1'b0}}, unsigned_lt};
            end
            ALU_XOR: begin
                result = operand_a ^ operand_b;
            end
            ALU_SRL: begin
                result = operand_a >> shamt;
            end
            ALU_SRA: begin
                // Sign bit fills from the left
                result = word_t'($signed(operand_a) >>> shamt);
            end
            ALU_OR: begin
                result = operand_a | operand_b;
            end
            ALU_AND: begin
                result = operand_a & operand_b;
            end
            default: begin
                // Unused encodings
                result = '0;
            end
        endcase
    end

endmodule

//--- rtl/rv_exec_pkg.sv
// Shared types for the RV32I execute stage
// Data word and register index widths
// ALU, operand select, branch and CSR operation encodings

package rv_exec_pkg;

    // Word width, fixed by RV32I
    localparam int XLEN = 32;

    // Data word
    typedef logic [XLEN-1:0] word_t;

    // Architectural register index
    typedef logic [4:0] reg_idx_t;

    // CSR immediate from the rs1 field
    typedef logic [4:0] zimm_t;

    // Integer ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // First ALU operand
    typedef enum logic [1:0] {
        ALU_OP1_SRC_RS1,
        ALU_OP1_SRC_PC,
        ALU_OP1_SRC_CSR,
        ALU_OP1_SRC_ZERO
    } alu_op1_src_e;

    // Second ALU operand
    typedef enum logic [1:0] {
        ALU_OP2_SRC_RS1,
        ALU_OP2_SRC_RS2,
        ALU_OP2_SRC_IMM,
        ALU_OP2_SRC_FOUR
    } alu_op2_src_e;

    // Branch conditions
    typedef enum logic [2:0] {
        CMP_EQ,
        CMP_NE,
        CMP_LT,
        CMP_GE,
        CMP_LTU,
        CMP_GEU
    } cmp_op_e;

    // CSR operand source
    typedef enum logic {
        CSR_OP_SRC_RS1,
        CSR_OP_SRC_ZIMM
    } csr_op_src_e;

    // CSR read-modify-write operation
    typedef enum logic [1:0] {
        CSR_ALU_OP_PASSTHRU,
        CSR_ALU_OP_BITSET,
        CSR_ALU_OP_BITCLEAR
    } csr_alu_op_e;

endpackage
